/* icache_cfg_pkg.sv */
package icache_cfg_pkg;

	// 16 KiB, 4 ways x 128 sets x 8 words
	localparam int WORDS_PER_LINE = 8;
	localparam int WAYS           = 4;
	localparam int SETS           = 128;

	localparam int INDEX_W  = 7;
	localparam int OFFSET_W = 3; // word offset within a line
	localparam int TAG_W    = 20;
	localparam int WAY_W    = 2;

	// one fetch address, seen raw or split into cache fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
			logic [1:0]          byte_off;
		} f;
	} addr_u;

endpackage

/* icache_mem_pkg.sv */
package icache_mem_pkg;

	localparam int BURST_BEATS = 8; // one beat per word of the line

	// refill fsm
	localparam logic [1:0] ST_SWEEP = 2'd0;
	localparam logic [1:0] ST_IDLE  = 2'd1;
	localparam logic [1:0] ST_FETCH = 2'd2; // request cycle
	localparam logic [1:0] ST_FILL  = 2'd3; // collecting beats

	localparam int PLRU_W = 3;

endpackage

/* icache_tag_store.sv */
module icache_tag_store (
	input  logic                                i_clk,
	input  logic                                i_rst,
	input  icache_cfg_pkg::addr_u               i_raddr,
	input  icache_cfg_pkg::addr_u               i_pa,
	input  logic                                i_wen,
	input  logic [icache_cfg_pkg::WAY_W-1:0]    i_wway,
	input  logic [icache_cfg_pkg::INDEX_W-1:0]  i_wset,
	input  logic [icache_cfg_pkg::TAG_W-1:0]    i_wtag,
	output logic                                o_hit,
	output logic [icache_cfg_pkg::WAY_W-1:0]    o_hit_way,
	output logic                                o_sweeping
);

	logic [icache_cfg_pkg::TAG_W-1:0] tag_mem [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	logic valid_mem [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];

	logic [icache_cfg_pkg::TAG_W-1:0] rd_tag [icache_cfg_pkg::WAYS];
	logic [icache_cfg_pkg::WAYS-1:0]  rd_valid;
	logic [icache_cfg_pkg::WAYS-1:0]  way_hit;
	logic [icache_cfg_pkg::INDEX_W-1:0] sweep_cnt;

	// one set per cycle after reset
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sweep_cnt  <= '0;
			o_sweeping <= 1'b1;
		end else if (o_sweeping) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == icache_cfg_pkg::INDEX_W'(icache_cfg_pkg::SETS - 1))
				o_sweeping <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			if (o_sweeping) begin
				valid_mem[w][sweep_cnt] <= 1'b0;
			end else if (i_wen && i_wway == icache_cfg_pkg::WAY_W'(w)) begin
				valid_mem[w][i_wset] <= 1'b1;
				tag_mem[w][i_wset]   <= i_wtag;
			end
		end
	end

	// line write to the set being read is forwarded
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			if (i_wen && i_wway == icache_cfg_pkg::WAY_W'(w) && i_wset == i_raddr.f.index) begin
				rd_valid[w] <= 1'b1;
				rd_tag[w]   <= i_wtag;
			end else begin
				rd_valid[w] <= valid_mem[w][i_raddr.f.index];
				rd_tag[w]   <= tag_mem[w][i_raddr.f.index];
			end
		end
	end

	always_comb begin
		o_hit_way = '0;
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			way_hit[w] = rd_valid[w] && (rd_tag[w] == i_pa.f.tag);
			if (way_hit[w])
				o_hit_way = o_hit_way | icache_cfg_pkg::WAY_W'(w);
		end
	end

	assign o_hit = |way_hit;

endmodule

/* icache_data_store.sv */
module icache_data_store (
	input  logic                                           i_clk,
	input  icache_cfg_pkg::addr_u                          i_raddr,
	input  logic                                           i_wen,
	input  logic [icache_cfg_pkg::WAY_W-1:0]               i_wway,
	input  logic [icache_cfg_pkg::INDEX_W-1:0]             i_wset,
	input  logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] i_wline,
	output logic [31:0]                                    o_rword
);

	logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0]
		line_mem [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
	logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] rd_line [icache_cfg_pkg::WAYS];

	always_ff @(posedge i_clk) begin
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			if (i_wen && i_wway == icache_cfg_pkg::WAY_W'(w))
				line_mem[w][i_wset] <= i_wline;
		end
	end

	// all four lines of the set, fill bypassed
	always_ff @(posedge i_clk) begin
		for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
			if (i_wen && i_wway == icache_cfg_pkg::WAY_W'(w) && i_wset == i_raddr.f.index)
				rd_line[w] <= i_wline;
			else
				rd_line[w] <= line_mem[w][i_raddr.f.index];
		end
	end

	// byte field carries the hit way of stage 2
	assign o_rword = rd_line[i_raddr.f.byte_off][i_raddr.f.offset];

endmodule

/* icache_plru.sv */
module icache_plru (
	input  logic                               i_clk,
	input  logic                               i_rst,
	input  logic [icache_cfg_pkg::INDEX_W-1:0] i_set,
	input  logic                               i_touch,
	input  logic [icache_cfg_pkg::WAY_W-1:0]   i_touch_way,
	output logic [icache_cfg_pkg::WAY_W-1:0]   o_victim
);

	logic [icache_mem_pkg::PLRU_W-1:0] lru_bits [icache_cfg_pkg::SETS];
	logic [icache_mem_pkg::PLRU_W-1:0] cur_bits;
	logic [icache_mem_pkg::PLRU_W-1:0] nxt_bits;

	assign cur_bits = lru_bits[i_set];

	// bit 1 picks the pair, bits 2 and 0 the way inside it
	always_comb begin
		if (!cur_bits[1])
			o_victim = cur_bits[2] ? 2'd2 : 2'd3;
		else
			o_victim = cur_bits[0] ? 2'd0 : 2'd1;
	end

	always_comb begin
		nxt_bits = cur_bits;
		case (i_touch_way)
			2'd0:    nxt_bits[1:0] = 2'b00;
			2'd1:    nxt_bits[1:0] = 2'b01;
			2'd2:    nxt_bits[2:1] = 2'b01;
			default: nxt_bits[2:1] = 2'b11;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			for (int s = 0; s < icache_cfg_pkg::SETS; s++)
				lru_bits[s] <= '0;
		end else if (i_touch) begin
			lru_bits[i_set] <= nxt_bits;
		end
	end

endmodule

/* icache_refill.sv */
module icache_refill (
	input  logic                                           i_clk,
	input  logic                                           i_rst,
	input  logic                                           i_miss,
	input  icache_cfg_pkg::addr_u                          i_miss_pa,
	input  logic [icache_cfg_pkg::WAY_W-1:0]               i_victim,
	input  logic                                           i_sweeping,
	input  logic                                           i_mem_rvalid,
	input  logic [31:0]                                    i_mem_rdata,
	input  logic                                           i_mem_rlast,
	output logic                                           o_mem_req,
	output icache_cfg_pkg::addr_u                          o_mem_addr,
	output logic                                           o_busy,
	output logic                                           o_word_valid,
	output logic [31:0]                                    o_word,
	output logic                                           o_lwen,
	output logic [icache_cfg_pkg::WAY_W-1:0]               o_lway,
	output logic [icache_cfg_pkg::INDEX_W-1:0]             o_lset,
	output logic [icache_cfg_pkg::TAG_W-1:0]               o_ltag,
	output logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] o_line
);

	logic [1:0] state;
	icache_cfg_pkg::addr_u miss_pa;
	logic [icache_cfg_pkg::OFFSET_W-1:0] beat_off;
	logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] line_buf;
	logic beat;

	assign beat = i_mem_rvalid && (state == icache_mem_pkg::ST_FILL);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state     <= icache_mem_pkg::ST_SWEEP;
			o_mem_req <= 1'b0;
			o_lwen    <= 1'b0;
		end else begin
			o_mem_req <= 1'b0;
			o_lwen    <= beat && i_mem_rlast; // whole line goes in next cycle
			case (state)
				icache_mem_pkg::ST_SWEEP: begin
					if (!i_sweeping)
						state <= icache_mem_pkg::ST_IDLE;
				end
				icache_mem_pkg::ST_IDLE: begin
					if (i_miss) begin
						state     <= icache_mem_pkg::ST_FETCH;
						o_mem_req <= 1'b1;
					end
				end
				icache_mem_pkg::ST_FETCH: state <= icache_mem_pkg::ST_FILL;
				default: begin
					if (beat && i_mem_rlast)
						state <= icache_mem_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// miss context and wrapping fill position
	always_ff @(posedge i_clk) begin
		if (state == icache_mem_pkg::ST_IDLE && i_miss) begin
			miss_pa  <= i_miss_pa;
			o_lway   <= i_victim;
			beat_off <= i_miss_pa.f.offset; // burst starts at the missed word
		end else if (beat) begin
			line_buf[beat_off] <= i_mem_rdata;
			beat_off <= icache_cfg_pkg::OFFSET_W'((beat_off + 1) % icache_mem_pkg::BURST_BEATS);
		end
	end

	// sweep stall ends as soon as the tag store is done
	assign o_busy = (state == icache_mem_pkg::ST_SWEEP && i_sweeping) ||
		state == icache_mem_pkg::ST_FETCH || state == icache_mem_pkg::ST_FILL;

	assign o_word_valid = beat && (beat_off == miss_pa.f.offset);
	assign o_word       = i_mem_rdata;

	always_comb begin
		o_mem_addr            = miss_pa;
		o_mem_addr.f.byte_off = 2'b00;
	end

	assign o_lset = miss_pa.f.index;
	assign o_ltag = miss_pa.f.tag;
	assign o_line = line_buf;

endmodule

/* icache_top.sv */
module icache_top (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_valid,
	input  icache_cfg_pkg::addr_u i_va,
	input  icache_cfg_pkg::addr_u i_pa,
	output logic                  o_valid,
	output logic [31:0]           o_data,
	output logic                  o_stall,
	output logic                  o_mem_req,
	output icache_cfg_pkg::addr_u o_mem_addr,
	input  logic                  i_mem_rvalid,
	input  logic [31:0]           i_mem_rdata,
	input  logic                  i_mem_rlast
);

	logic s1_valid;
	logic [icache_cfg_pkg::OFFSET_W-1:0] s1_off;

	logic hit;
	logic [icache_cfg_pkg::WAY_W-1:0] hit_way;
	logic sweeping;
	logic hit_fetch;
	logic miss;
	logic [icache_cfg_pkg::WAY_W-1:0] victim;
	logic [31:0] rword;
	icache_cfg_pkg::addr_u data_raddr;

	logic refill_busy;
	logic word_valid;
	logic [31:0] refill_word;
	logic lwen;
	logic [icache_cfg_pkg::WAY_W-1:0] lway;
	logic [icache_cfg_pkg::INDEX_W-1:0] lset;
	logic [icache_cfg_pkg::TAG_W-1:0] ltag;
	logic [icache_cfg_pkg::WORDS_PER_LINE-1:0][31:0] line;

	assign hit_fetch = s1_valid && hit;
	assign miss      = s1_valid && !hit && !refill_busy;
	assign o_stall   = refill_busy || miss; // anything presented now is dropped

	always_ff @(posedge i_clk) begin
		if (i_rst || o_stall)
			s1_valid <= 1'b0;
		else
			s1_valid <= i_valid;
		s1_off <= i_va.f.offset;
	end

	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_valid <= 1'b0;
		else
			o_valid <= hit_fetch || word_valid;
	end

	always_ff @(posedge i_clk) begin
		o_data <= word_valid ? refill_word : rword;
	end

	// read index from the new fetch, word select from stage 2
	always_comb begin
		data_raddr            = i_va;
		data_raddr.f.offset   = s1_off;
		data_raddr.f.byte_off = hit_way;
	end

	icache_tag_store u_tag_store (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_raddr    (i_va),
		.i_pa       (i_pa),
		.i_wen      (lwen),
		.i_wway     (lway),
		.i_wset     (lset),
		.i_wtag     (ltag),
		.o_hit      (hit),
		.o_hit_way  (hit_way),
		.o_sweeping (sweeping)
	);

	icache_data_store u_data_store (
		.i_clk   (i_clk),
		.i_raddr (data_raddr),
		.i_wen   (lwen),
		.i_wway  (lway),
		.i_wset  (lset),
		.i_wline (line),
		.o_rword (rword)
	);

	// a miss touches the victim, i.e. the way about to be filled
	icache_plru u_plru (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_set       (i_pa.f.index),
		.i_touch     (hit_fetch || miss),
		.i_touch_way (hit_fetch ? hit_way : victim),
		.o_victim    (victim)
	);

	icache_refill u_refill (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_miss       (miss),
		.i_miss_pa    (i_pa),
		.i_victim     (victim),
		.i_sweeping   (sweeping),
		.i_mem_rvalid (i_mem_rvalid),
		.i_mem_rdata  (i_mem_rdata),
		.i_mem_rlast  (i_mem_rlast),
		.o_mem_req    (o_mem_req),
		.o_mem_addr   (o_mem_addr),
		.o_busy       (refill_busy),
		.o_word_valid (word_valid),
		.o_word       (refill_word),
		.o_lwen       (lwen),
		.o_lway       (lway),
		.o_lset       (lset),
		.o_ltag       (ltag),
		.o_line       (line)
	);

endmodule

/* tb_icache_mem.sv */
module tb_icache_mem (
	input  logic                  i_clk,
	input  logic                  i_req,
	input  icache_cfg_pkg::addr_u i_addr,
	output logic                  o_rvalid,
	output logic [31:0]           o_rdata,
	output logic                  o_rlast
);

	integer seed;

	// contents follow from the byte address alone
	function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
		return byte_addr ^ 32'h1c0ffee0;
	endfunction

	initial begin
		logic [31:0] base;
		logic [2:0] word;
		int gap;
		seed = 32'hfef1;
		o_rvalid = 1'b0;
		o_rdata = '0;
		o_rlast = 1'b0;
		forever begin
			@(posedge i_clk);
			#2;
			o_rvalid = 1'b0;
			o_rlast = 1'b0;
			if (i_req) begin
				base = {i_addr.raw[31:5], 5'b00000};
				word = i_addr.f.offset; // critical word goes first
				for (int b = 0; b < icache_mem_pkg::BURST_BEATS; b++) begin
					gap = {$random(seed)} % 3;
					repeat (gap) begin
						@(posedge i_clk);
						#2;
						o_rvalid = 1'b0;
					end
					@(posedge i_clk);
					#2;
					o_rvalid = 1'b1;
					o_rdata = word_at(base | {word, 2'b00});
					o_rlast = (b == icache_mem_pkg::BURST_BEATS - 1);
					word = word + 1'b1; // wraps inside the line
				end
			end
		end
	end

endmodule

/* tb_icache.sv */
module tb_icache;

	localparam int TIMEOUT = 500;

	logic                  i_clk;
	logic                  i_rst;
	logic                  i_valid;
	icache_cfg_pkg::addr_u i_va;
	icache_cfg_pkg::addr_u i_pa;
	logic                  o_valid;
	logic [31:0]           o_data;
	logic                  o_stall;
	logic                  o_mem_req;
	icache_cfg_pkg::addr_u o_mem_addr;
	logic                  mem_rvalid;
	logic [31:0]           mem_rdata;
	logic                  mem_rlast;

	logic [31:0] vec_va [$];
	logic [31:0] vec_pa [$];
	logic        vec_miss [$];

	// reference cache state
	logic [19:0] ref_tag [4][128];
	logic        ref_valid [4][128];
	logic [2:0]  ref_lru [128];

	icache_top uut (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_valid      (i_valid),
		.i_va         (i_va),
		.i_pa         (i_pa),
		.o_valid      (o_valid),
		.o_data       (o_data),
		.o_stall      (o_stall),
		.o_mem_req    (o_mem_req),
		.o_mem_addr   (o_mem_addr),
		.i_mem_rvalid (mem_rvalid),
		.i_mem_rdata  (mem_rdata),
		.i_mem_rlast  (mem_rlast)
	);

	tb_icache_mem u_mem (
		.i_clk    (i_clk),
		.i_req    (o_mem_req),
		.i_addr   (o_mem_addr),
		.o_rvalid (mem_rvalid),
		.o_rdata  (mem_rdata),
		.o_rlast  (mem_rlast)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	task automatic fail_now(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input icache_cfg_pkg::addr_u exp,
			input icache_cfg_pkg::addr_u act);
		if (act.raw !== exp.raw)
			fail_now($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp.raw, act.raw));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_now($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
	endtask

	function automatic logic [31:0] expected_word(input logic [31:0] pa);
		return {pa[31:2], 2'b00} ^ 32'h1c0ffee0;
	endfunction

	// tag lookup and tree plru with fill on miss
	task automatic model_access(input logic [31:0] pa, output logic miss);
		int idx;
		int way;
		idx = pa[11:5];
		way = -1;
		for (int w = 0; w < 4; w++)
			if (ref_valid[w][idx] && ref_tag[w][idx] == pa[31:12])
				way = w;
		miss = (way < 0);
		if (miss) begin
			if (!ref_lru[idx][1])
				way = ref_lru[idx][2] ? 2 : 3;
			else
				way = ref_lru[idx][0] ? 0 : 1;
			ref_valid[way][idx] = 1'b1;
			ref_tag[way][idx] = pa[31:12];
		end
		case (way)
			0:       ref_lru[idx] = {ref_lru[idx][2], 2'b00};
			1:       ref_lru[idx] = {ref_lru[idx][2], 2'b01};
			2:       ref_lru[idx] = {2'b01, ref_lru[idx][0]};
			default: ref_lru[idx] = {2'b11, ref_lru[idx][0]};
		endcase
	endtask

	task automatic load_vectors();
		int fd;
		reg [8*160-1:0] text;
		logic [31:0] va;
		logic [31:0] pa;
		logic m;
		fd = $fopen("icache_vectors.txt", "r");
		if (fd == 0)
			fail_now("could not open icache_vectors.txt");
		while (!$feof(fd)) begin
			text = '0;
			if ($fgets(text, fd) > 0 && $sscanf(text, "%h %h %h", va, pa, m) == 3) begin
				vec_va.push_back(va);
				vec_pa.push_back(pa);
				vec_miss.push_back(m);
			end
		end
		$fclose(fd);
		if (vec_va.size() == 0)
			fail_now("the vector file holds no fetches");
	endtask

	task automatic sweep_phase();
		for (int c = 0; c < icache_cfg_pkg::SETS; c++) begin
			@(negedge i_clk);
			check_flag("sweep stall", 1'b1, o_stall);
			check_flag("sweep valid", 1'b0, o_valid);
			check_flag("sweep request", 1'b0, o_mem_req);
		end
		@(negedge i_clk);
		check_flag("stall after sweep", 1'b0, o_stall);
	endtask

	// runs from the miss cycle until stall drops
	task automatic follow_refill(input int n, input logic [31:0] pa);
		icache_cfg_pkg::addr_u exp_addr;
		int cycles;
		int beats;
		logic word_due;
		logic last_seen;
		exp_addr.raw = {pa[31:2], 2'b00};
		cycles = 0;
		beats = 0;
		word_due = 1'b0;
		last_seen = 1'b0;
		while (o_stall) begin
			@(posedge i_clk);
			@(negedge i_clk);
			cycles++;
			if (cycles > TIMEOUT)
				fail_now($sformatf("refill for fetch %0d did not finish in time", n));
			// stall ends the cycle after the last beat
			check_flag($sformatf("fetch %0d refill stall", n), !last_seen, o_stall);
			check_flag($sformatf("fetch %0d memory request", n), cycles == 1, o_mem_req);
			if (o_mem_req)
				check_addr($sformatf("fetch %0d request address", n), exp_addr, o_mem_addr);
			// first beat carries the missed word
			check_flag($sformatf("fetch %0d critical word valid", n), word_due, o_valid);
			if (o_valid)
				check_word($sformatf("fetch %0d critical word", n), expected_word(pa), o_data);
			word_due = mem_rvalid && beats == 0;
			if (mem_rvalid)
				beats++;
			last_seen = mem_rvalid && mem_rlast;
		end
	endtask

	task automatic stream_fetches();
		int next;
		int s2;
		int pend_idx;
		int idle;
		logic pend;
		logic miss;
		next = 0;
		s2 = -1;
		pend_idx = 0;
		idle = 0;
		pend = 1'b0;
		while (next < vec_va.size() || s2 >= 0 || pend) begin
			@(posedge i_clk);
			#2;
			if (s2 >= 0)
				i_pa.raw = vec_pa[s2]; // translation of the stage 2 fetch
			i_valid = (next < vec_va.size());
			if (i_valid)
				i_va.raw = vec_va[next];
			@(negedge i_clk);
			check_flag($sformatf("fetch %0d valid", pend_idx), pend, o_valid);
			if (pend)
				check_word($sformatf("fetch %0d data", pend_idx),
					expected_word(vec_pa[pend_idx]), o_data);
			pend = 1'b0;
			if (s2 >= 0) begin
				model_access(vec_pa[s2], miss);
				check_flag($sformatf("fetch %0d model", s2), vec_miss[s2], miss);
				check_flag($sformatf("fetch %0d stall", s2), miss, o_stall);
				if (miss) begin
					follow_refill(s2, vec_pa[s2]);
				end else begin
					pend = 1'b1;
					pend_idx = s2;
				end
			end
			s2 = -1;
			if (i_valid && !o_stall) begin
				s2 = next;
				next++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT)
					fail_now("no fetch was accepted for too long");
			end
		end
		i_valid = 1'b0;
	endtask

	initial begin
		i_rst = 1'b1;
		i_valid = 1'b0;
		i_va = '0;
		i_pa = '0;
		for (int s = 0; s < 128; s++) begin
			ref_lru[s] = 3'b000;
			for (int w = 0; w < 4; w++) begin
				ref_valid[w][s] = 1'b0;
				ref_tag[w][s] = '0;
			end
		end
		load_vectors();
		repeat (10) @(posedge i_clk);
		#2;
		i_rst = 1'b0;
		sweep_phase();
		stream_fetches();
		repeat (2) @(posedge i_clk);
		$display("sim passed");
		$finish;
	end

endmodule

/* icache_vectors.txt */
# columns: virtual address, physical address, expected miss flag (all hex)
# va and pa share bits 11:0, so set and word offset agree
00004034 80001034 1
00004020 80001020 0
0000403c 8000103c 0
00004024 80001024 0
00004038 80001038 0
00004034 90002034 1
00004024 90002024 0
00004030 80001030 0
00007208 10000208 1
00007214 10001214 1
0000721c 1000221c 1
00007200 10003200 1
00007204 10004204 1
00007210 10000210 1
00007218 10002218 0
0000720c 1000320c 0
00007200 10001200 1
0000721c 1000421c 1
00007204 10002204 0
00007208 10003208 0

/* icache.f */
icache_cfg_pkg.sv
icache_mem_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_plru.sv
icache_refill.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - icache_cfg_pkg.sv
  - icache_mem_pkg.sv
  - icache_tag_store.sv
  - icache_data_store.sv
  - icache_plru.sv
  - icache_refill.sv
  - icache_top.sv
  - target: test
    files:
      - tb_icache_mem.sv
      - tb_icache.sv
